// File: src.f
+incdir+verilog
verilog/host_if_pkg.sv
verilog/dma_pkg.sv
verilog/dma_cmd_ctrl.sv
verilog/host_to_lmem_copy.sv
verilog/lmem_to_host_copy.sv
verilog/lmem_arbiter.sv
verilog/dma_afu_top.sv
testbench/tb_dma_afu.sv

// File: Bender.yml
package:
  name: dma_afu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/host_if_pkg.sv
      - verilog/dma_pkg.sv
      - verilog/dma_cmd_ctrl.sv
      - verilog/host_to_lmem_copy.sv
      - verilog/lmem_to_host_copy.sv
      - verilog/lmem_arbiter.sv
      - verilog/dma_afu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_dma_afu.sv

// File: testbench/tb_dma_afu.sv
`default_nettype none

`include "dma_cfg.svh"

module tb_dma_afu;

  localparam int TOTAL_LINES = 20 + 13 + 10;   // Lines moved over all tests
  localparam int MAX_CYCLES  = 10 + TOTAL_LINES * 40 + 5 * 300;
  localparam int MARGIN      = 8;              // Lines checked around each region

  logic                      clk;
  logic                      reset;
  host_if_pkg::mmio_req_t    mmio_req;
  host_if_pkg::mmio_rsp_t    mmio_rsp;
  logic                      host_rd_req_valid;
  host_if_pkg::host_rd_req_t host_rd_req;
  logic                      host_rd_req_ready;
  host_if_pkg::host_rd_rsp_t host_rd_rsp;
  logic                      host_wr_req_valid;
  host_if_pkg::host_wr_req_t host_wr_req;
  logic                      host_wr_req_ready;
  logic                      host_wr_ack;
  logic                      lmem_req_valid;
  dma_pkg::lmem_req_t        lmem_req;
  logic                      lmem_req_ready;
  dma_pkg::lmem_rsp_t        lmem_rsp;

  integer seed = 32'hdb74_3387;
  int     n_checks = 0;
  int     n_errors = 0;

  logic [63:0]           host_mem [4096];
  logic [63:0]           lmem_mem [4096];
  logic [`DMA_TAG_W-1:0] win_tag [$];
  logic [63:0]           win_data [$];
  logic [`DMA_TAG_W-1:0] reply_tag [$];
  logic [63:0]           reply_data [$];
  logic [63:0]           lmem_rd_q [$];
  int reply_gap, lmem_gap, ack_gap, ack_owed;
  int h2l_count, rd_issued;
  int n_host_rd, n_host_wr, n_lmem;

  // Compare process inputs
  logic  cmp_req = 1'b0;
  bit    cmp_to_lmem;
  int    cmp_src, cmp_dst, cmp_count;
  string cmp_name;

  dma_afu_top dut (
    .clk               (clk),
    .reset             (reset),
    .mmio_req          (mmio_req),
    .mmio_rsp          (mmio_rsp),
    .host_rd_req_valid (host_rd_req_valid),
    .host_rd_req       (host_rd_req),
    .host_rd_req_ready (host_rd_req_ready),
    .host_rd_rsp       (host_rd_rsp),
    .host_wr_req_valid (host_wr_req_valid),
    .host_wr_req       (host_wr_req),
    .host_wr_req_ready (host_wr_req_ready),
    .host_wr_ack       (host_wr_ack),
    .lmem_req_valid    (lmem_req_valid),
    .lmem_req          (lmem_req),
    .lmem_req_ready    (lmem_req_ready),
    .lmem_rsp          (lmem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] host_fill(input int a);
    return {32'(32'h4857_0000 + a), 32'(~(a * 32'h9e37_79b9))};
  endfunction

  function automatic logic [63:0] lmem_fill(input int a);
    return {32'(32'h4c4d_0000 + a), 32'((a * 32'h0101_0101) ^ 32'h5a5a_5a5a)};
  endfunction

  // Expected destination line after a copy of count lines from src to dst
  function automatic logic [63:0] expected_line(input bit to_lmem, input int src,
                                                input int dst, input int count, input int a);
    if (a >= dst && a < dst + count) begin
      return to_lmem ? host_mem[src + a - dst] : lmem_mem[src + a - dst];
    end
    return to_lmem ? lmem_fill(a) : host_fill(a);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Host and local memory models
  initial begin
    for (int a = 0; a < 4096; a++) begin
      host_mem[a] = host_fill(a);
      lmem_mem[a] = lmem_fill(a);
    end
    host_rd_req_ready = 1'b0;
    host_rd_rsp       = '0;
    host_wr_req_ready = 1'b0;
    host_wr_ack       = 1'b0;
    lmem_req_ready    = 1'b0;
    lmem_rsp          = '0;
    forever begin
      @(negedge clk);
      host_rd_rsp = '0;
      if (reply_tag.size() > 0) begin
        if (reply_gap > 0) begin
          reply_gap--;
        end else begin
          host_rd_rsp.valid = 1'b1;
          host_rd_rsp.tag   = reply_tag.pop_front();
          host_rd_rsp.data  = reply_data.pop_front();
          reply_gap = $unsigned($random(seed)) % 4;
        end
      end
      lmem_rsp = '0;
      if (lmem_rd_q.size() > 0) begin
        if (lmem_gap > 0) begin
          lmem_gap--;
        end else begin
          lmem_rsp.valid = 1'b1;
          lmem_rsp.data  = lmem_rd_q.pop_front();
          lmem_gap = $unsigned($random(seed)) % 3;
        end
      end
      host_wr_ack = 1'b0;
      if (ack_owed > 0) begin
        if (ack_gap > 0) begin
          ack_gap--;
        end else begin
          host_wr_ack = 1'b1;
          ack_owed--;
          ack_gap = $unsigned($random(seed)) % 5;
        end
      end
      host_rd_req_ready = ($random(seed) & 3) != 0;
      host_wr_req_ready = ($random(seed) & 1) != 0;
      lmem_req_ready    = ($random(seed) & 3) != 0;
      #1;
      // Transfers that the next rising edge completes
      if (host_rd_req_valid && host_rd_req_ready) begin
        win_tag.push_back(host_rd_req.tag);
        win_data.push_back(host_mem[host_rd_req.addr[11:0]]);
        n_host_rd++;
        rd_issued++;
        if (win_tag.size() == `DMA_WINDOW || rd_issued == h2l_count) begin
          while (win_tag.size() > 0) begin   // Reversed tag order
            reply_tag.push_back(win_tag.pop_back());
            reply_data.push_back(win_data.pop_back());
          end
        end
      end
      if (lmem_req_valid && lmem_req_ready) begin
        n_lmem++;
        if (lmem_req.rw) lmem_mem[lmem_req.addr[11:0]] = lmem_req.data;
        else lmem_rd_q.push_back(lmem_mem[lmem_req.addr[11:0]]);
      end
      if (host_wr_req_valid && host_wr_req_ready) begin
        host_mem[host_wr_req.addr[11:0]] = host_wr_req.data;
        n_host_wr++;
        ack_owed++;
      end
    end
  end

  initial begin
    forever begin
      wait (cmp_req);
      for (int a = cmp_dst - MARGIN; a < cmp_dst + cmp_count + MARGIN; a++) begin
        check_value(cmp_name, expected_line(cmp_to_lmem, cmp_src, cmp_dst, cmp_count, a),
                    cmp_to_lmem ? lmem_mem[a] : host_mem[a]);
      end
      cmp_req = 1'b0;
    end
  end

  task automatic compare_region(input string name, input bit to_lmem, input int src,
                                input int dst, input int count);
    cmp_name    = name;
    cmp_to_lmem = to_lmem;
    cmp_src     = src;
    cmp_dst     = dst;
    cmp_count   = count;
    cmp_req     = 1'b1;
    wait (!cmp_req);
  endtask

  task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
    @(negedge clk);
    mmio_req          = '0;
    mmio_req.wr_valid = 1'b1;
    mmio_req.addr     = addr;
    mmio_req.data     = data;
    @(negedge clk);
    mmio_req = '0;
  endtask

  task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
    @(negedge clk);
    mmio_req          = '0;
    mmio_req.rd_valid = 1'b1;
    mmio_req.addr     = addr;
    @(negedge clk);
    mmio_req = '0;
    check_value("mmio read response valid", 64'd1, 64'(mmio_rsp.valid));
    data = mmio_rsp.data;
  endtask

  task automatic start_copy(input int host_addr, input int lmem_addr, input int count,
                            input dma_pkg::dma_cmd_e code);
    if (code == dma_pkg::CMD_TO_LMEM) begin
      h2l_count = count;
      rd_issued = 0;
    end
    mmio_write(`DMA_REG_HOST_ADDR, 64'(host_addr));
    mmio_write(`DMA_REG_LMEM_ADDR, 64'(lmem_addr));
    mmio_write(`DMA_REG_SIZE, 64'(count));
    mmio_write(`DMA_REG_CMD, 64'(code));
  endtask

  task automatic wait_idle();
    logic [63:0] st;
    st = 64'hffff;
    while (st != 64'h0) mmio_read(`DMA_REG_STATUS, st);
  endtask

  initial begin
    logic [63:0] v;
    int          rd0, wr0, lm0;
    mmio_req = '0;
    reset    = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_value("reset host_rd_req_valid", 64'd0, 64'(host_rd_req_valid));
    check_value("reset host_wr_req_valid", 64'd0, 64'(host_wr_req_valid));
    check_value("reset lmem_req_valid", 64'd0, 64'(lmem_req_valid));
    check_value("reset mmio_rsp valid", 64'd0, 64'(mmio_rsp.valid));
    mmio_read(`DMA_REG_STATUS, v);
    check_value("reset status", 64'd0, v);
    mmio_read(16'h0040, v);
    check_value("unmapped read", 64'd0, v);

    start_copy(32'h020, 16'h105, 20, dma_pkg::CMD_TO_LMEM);   // Three windows
    wait_idle();
    compare_region("host to lmem 20 lines", 1'b1, 32'h020, 16'h105, 20);

    start_copy(32'h500, 16'h105, 13, dma_pkg::CMD_TO_HOST);
    mmio_read(`DMA_REG_STATUS, v);
    check_value("status during lmem to host", 64'd2, v);
    wait_idle();
    compare_region("lmem to host 13 lines", 1'b0, 16'h105, 32'h500, 13);

    rd0 = n_host_rd;
    wr0 = n_host_wr;
    lm0 = n_lmem;
    start_copy(32'h800, 16'h900, 0, dma_pkg::CMD_TO_HOST);
    wait_idle();
    check_value("zero count host reads", 64'(rd0), 64'(n_host_rd));
    check_value("zero count host writes", 64'(wr0), 64'(n_host_wr));
    check_value("zero count lmem requests", 64'(lm0), 64'(n_lmem));
    compare_region("zero count host region", 1'b0, 16'h900, 32'h800, 0);

    wr0 = n_host_wr;
    start_copy(32'h300, 16'h700, 10, dma_pkg::CMD_TO_LMEM);
    mmio_read(`DMA_REG_STATUS, v);
    check_value("status during host to lmem", 64'd1, v);
    // Second command lands while busy
    mmio_write(`DMA_REG_HOST_ADDR, 64'h200);
    mmio_write(`DMA_REG_LMEM_ADDR, 64'h600);
    mmio_write(`DMA_REG_SIZE, 64'd5);
    mmio_write(`DMA_REG_CMD, 64'(dma_pkg::CMD_TO_HOST));
    wait_idle();
    repeat (20) @(negedge clk);
    mmio_read(`DMA_REG_STATUS, v);
    check_value("status after ignored command", 64'd0, v);
    check_value("ignored command host writes", 64'(wr0), 64'(n_host_wr));
    compare_region("first copy while busy", 1'b1, 32'h300, 16'h700, 10);
    compare_region("ignored lmem region", 1'b1, 32'h200, 16'h600, 0);
    compare_region("ignored host region", 1'b0, 16'h600, 32'h200, 0);

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the DMA did not finish within %0d cycles", MAX_CYCLES);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/dma_afu_top.sv
`default_nettype none

module dma_afu_top (
  input  logic                      clk,
  input  logic                      reset,
  input  host_if_pkg::mmio_req_t    mmio_req,
  output host_if_pkg::mmio_rsp_t    mmio_rsp,
  output logic                      host_rd_req_valid,
  output host_if_pkg::host_rd_req_t host_rd_req,
  input  logic                      host_rd_req_ready,
  input  host_if_pkg::host_rd_rsp_t host_rd_rsp,
  output logic                      host_wr_req_valid,
  output host_if_pkg::host_wr_req_t host_wr_req,
  input  logic                      host_wr_req_ready,
  input  logic                      host_wr_ack,
  output logic                      lmem_req_valid,
  output dma_pkg::lmem_req_t        lmem_req,
  input  logic                      lmem_req_ready,
  input  dma_pkg::lmem_rsp_t        lmem_rsp
);

  dma_pkg::copy_cmd_t cmd;
  logic               to_lmem_start;
  logic               to_host_start;
  logic               to_lmem_done;
  logic               to_host_done;
  logic               h2l_req_valid;
  logic               h2l_req_ready;
  dma_pkg::lmem_req_t h2l_req;
  logic               l2h_req_valid;
  logic               l2h_req_ready;
  dma_pkg::lmem_req_t l2h_req;
  dma_pkg::lmem_rsp_t l2h_rsp;
  logic               l2h_rsp_ready;

  dma_cmd_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .mmio_req      (mmio_req),
    .mmio_rsp      (mmio_rsp),
    .to_lmem_start (to_lmem_start),
    .to_host_start (to_host_start),
    .cmd           (cmd),
    .to_lmem_done  (to_lmem_done),
    .to_host_done  (to_host_done)
  );

  host_to_lmem_copy u_h2l (
    .clk               (clk),
    .reset             (reset),
    .start             (to_lmem_start),
    .cmd               (cmd),
    .done              (to_lmem_done),
    .host_rd_req_valid (host_rd_req_valid),
    .host_rd_req       (host_rd_req),
    .host_rd_req_ready (host_rd_req_ready),
    .host_rd_rsp       (host_rd_rsp),
    .lmem_req_valid    (h2l_req_valid),
    .lmem_req          (h2l_req),
    .lmem_req_ready    (h2l_req_ready)
  );

  lmem_to_host_copy u_l2h (
    .clk               (clk),
    .reset             (reset),
    .start             (to_host_start),
    .cmd               (cmd),
    .done              (to_host_done),
    .lmem_req_valid    (l2h_req_valid),
    .lmem_req          (l2h_req),
    .lmem_req_ready    (l2h_req_ready),
    .lmem_rsp          (l2h_rsp),
    .lmem_rsp_ready    (l2h_rsp_ready),
    .host_wr_req_valid (host_wr_req_valid),
    .host_wr_req       (host_wr_req),
    .host_wr_req_ready (host_wr_req_ready),
    .host_wr_ack       (host_wr_ack)
  );

  // h2l only writes, so its response port stays open
  lmem_arbiter u_arb (
    .clk            (clk),
    .reset          (reset),
    .h2l_req_valid  (h2l_req_valid),
    .h2l_req_ready  (h2l_req_ready),
    .h2l_req        (h2l_req),
    .h2l_rsp        (),
    .h2l_rsp_ready  (1'b1),
    .l2h_req_valid  (l2h_req_valid),
    .l2h_req_ready  (l2h_req_ready),
    .l2h_req        (l2h_req),
    .l2h_rsp        (l2h_rsp),
    .l2h_rsp_ready  (l2h_rsp_ready),
    .lmem_req_valid (lmem_req_valid),
    .lmem_req       (lmem_req),
    .lmem_req_ready (lmem_req_ready),
    .lmem_rsp       (lmem_rsp)
  );

endmodule

`default_nettype wire

// File: verilog/lmem_arbiter.sv
`default_nettype none

`include "dma_cfg.svh"

module lmem_arbiter (
  input  logic               clk,
  input  logic               reset,
  input  logic               h2l_req_valid,
  output logic               h2l_req_ready,
  input  dma_pkg::lmem_req_t h2l_req,
  output dma_pkg::lmem_rsp_t h2l_rsp,
  input  logic               h2l_rsp_ready,
  input  logic               l2h_req_valid,
  output logic               l2h_req_ready,
  input  dma_pkg::lmem_req_t l2h_req,
  output dma_pkg::lmem_rsp_t l2h_rsp,
  input  logic               l2h_rsp_ready,
  output logic               lmem_req_valid,
  output dma_pkg::lmem_req_t lmem_req,
  input  logic               lmem_req_ready,
  input  dma_pkg::lmem_rsp_t lmem_rsp
);

  localparam int PW = $clog2(`DMA_ARB_DEPTH);

  logic                   src_fifo [`DMA_ARB_DEPTH];   // 1 = l2h
  logic [PW:0]            wr_ptr;
  logic [PW:0]            rd_ptr;
  logic                   fifo_full;
  logic                   grant_l2h;
  logic                   push;
  logic                   rsp_valid_q;
  logic                   rsp_src_q;
  logic [`DMA_LINE_W-1:0] rsp_data_q;
  logic                   rsp_taken;

  // h2l has priority
  assign grant_l2h      = !h2l_req_valid;
  assign lmem_req_valid = h2l_req_valid || l2h_req_valid;
  assign lmem_req       = grant_l2h ? l2h_req : h2l_req;
  assign h2l_req_ready  = lmem_req_ready;
  assign l2h_req_ready  = lmem_req_ready && grant_l2h;

  assign push      = lmem_req_valid && lmem_req_ready && !lmem_req.rw;
  assign fifo_full = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
  assign rsp_taken = rsp_src_q ? l2h_rsp_ready : h2l_rsp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      rsp_valid_q <= 1'b0;
      rsp_src_q   <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (lmem_rsp.valid) begin
        rd_ptr      <= rd_ptr + 1'b1;
        rsp_valid_q <= 1'b1;
        rsp_src_q   <= src_fifo[rd_ptr[PW-1:0]];
      end else if (rsp_taken) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) src_fifo[wr_ptr[PW-1:0]] <= grant_l2h;
    if (lmem_rsp.valid) rsp_data_q <= lmem_rsp.data;
  end

  // Response held until the source takes it
  assign h2l_rsp = '{valid: rsp_valid_q && !rsp_src_q, data: rsp_data_q};
  assign l2h_rsp = '{valid: rsp_valid_q && rsp_src_q, data: rsp_data_q};

  a_fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !fifo_full);
  a_rsp_no_overwrite: assert property (@(posedge clk) disable iff (reset)
    lmem_rsp.valid |-> !rsp_valid_q || rsp_taken);

endmodule

`default_nettype wire

// File: verilog/lmem_to_host_copy.sv
`default_nettype none

`include "dma_cfg.svh"

module lmem_to_host_copy (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  dma_pkg::copy_cmd_t        cmd,
  output logic                      done,
  output logic                      lmem_req_valid,
  output dma_pkg::lmem_req_t        lmem_req,
  input  logic                      lmem_req_ready,
  input  dma_pkg::lmem_rsp_t        lmem_rsp,
  output logic                      lmem_rsp_ready,
  output logic                      host_wr_req_valid,
  output host_if_pkg::host_wr_req_t host_wr_req,
  input  logic                      host_wr_req_ready,
  input  logic                      host_wr_ack
);

  logic                    active;
  logic                    rd_busy;    // One local read in flight
  logic [`DMA_LADDR_W-1:0] rd_addr;
  logic [`DMA_HADDR_W-1:0] wr_addr;
  logic [`DMA_CNT_W-1:0]   rd_left;
  logic [`DMA_CNT_W-1:0]   wr_left;
  logic [`DMA_CNT_W-1:0]   ack_pend;
  logic                    rd_fire;
  logic                    wr_fire;

  assign rd_fire = lmem_req_valid && lmem_req_ready;
  assign wr_fire = host_wr_req_valid && host_wr_req_ready;

  assign lmem_req_valid = active && (rd_left != '0) && !rd_busy;
  assign lmem_req       = '{rw: 1'b0, addr: rd_addr, data: '0};

  // Read data goes straight out as the host write
  assign host_wr_req_valid = lmem_rsp.valid;
  assign host_wr_req       = '{addr: wr_addr, data: lmem_rsp.data};
  assign lmem_rsp_ready    = host_wr_req_ready;

  assign done = active && (wr_left == '0) && (ack_pend == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      rd_busy  <= 1'b0;
      rd_left  <= '0;
      wr_left  <= '0;
      ack_pend <= '0;
    end else begin
      if (start) begin
        active  <= 1'b1;
        rd_left <= cmd.count;
        wr_left <= cmd.count;
      end else if (done) begin
        active <= 1'b0;
      end
      if (rd_fire) begin
        rd_busy <= 1'b1;
        rd_left <= rd_left - 1'b1;
      end
      if (wr_fire) begin
        rd_busy <= 1'b0;
        wr_left <= wr_left - 1'b1;
      end
      ack_pend <= ack_pend + `DMA_CNT_W'(wr_fire) - `DMA_CNT_W'(host_wr_ack);
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rd_addr <= cmd.lmem_addr;
      wr_addr <= cmd.host_addr;
    end else begin
      if (rd_fire) rd_addr <= rd_addr + 1'b1;
      if (wr_fire) wr_addr <= wr_addr + 1'b1;
    end
  end

  a_ack_after_write: assert property (@(posedge clk) disable iff (reset)
    host_wr_ack |-> ack_pend != '0);

endmodule

`default_nettype wire

// File: verilog/host_to_lmem_copy.sv
`default_nettype none

`include "dma_cfg.svh"

module host_to_lmem_copy (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  dma_pkg::copy_cmd_t        cmd,
  output logic                      done,
  output logic                      host_rd_req_valid,
  output host_if_pkg::host_rd_req_t host_rd_req,
  input  logic                      host_rd_req_ready,
  input  host_if_pkg::host_rd_rsp_t host_rd_rsp,
  output logic                      lmem_req_valid,
  output dma_pkg::lmem_req_t        lmem_req,
  input  logic                      lmem_req_ready
);

  localparam int QW = $clog2(`DMA_RDQ_DEPTH);

  typedef struct packed {
    logic [`DMA_TAG_W-1:0]  tag;
    logic [`DMA_LINE_W-1:0] data;
  } rdq_entry_t;

  logic                    active;
  logic [`DMA_HADDR_W-1:0] host_base;
  logic [`DMA_LADDR_W-1:0] lmem_base;
  logic [`DMA_CNT_W-1:0]   count_q;
  logic [`DMA_CNT_W-1:0]   req_cnt;
  logic [`DMA_CNT_W-1:0]   rsp_cnt;
  logic [`DMA_CNT_W-1:0]   wr_cnt;
  logic [`DMA_WINDOW-1:0]  tag_seen;
  rdq_entry_t              rdq_mem [`DMA_RDQ_DEPTH];
  rdq_entry_t              rdq_head;
  logic [QW:0]             rdq_wr_ptr;
  logic [QW:0]             rdq_rd_ptr;
  logic                    window_open;
  logic                    queue_room;
  logic                    rd_fire;
  logic                    rsp_fire;
  logic                    wr_fire;

  assign rd_fire  = host_rd_req_valid && host_rd_req_ready;
  assign rsp_fire = active && host_rd_rsp.valid;
  assign wr_fire  = lmem_req_valid && lmem_req_ready;

  // Hold at a window boundary until every earlier reply is in
  assign window_open = (req_cnt[`DMA_TAG_W-1:0] != '0) || (rsp_cnt == req_cnt);
  assign queue_room  = (req_cnt - wr_cnt) < `DMA_CNT_W'(`DMA_RDQ_DEPTH);

  assign host_rd_req_valid = active && (req_cnt != count_q) && window_open && queue_room;
  assign host_rd_req = '{addr: host_base + `DMA_HADDR_W'(req_cnt),
                         tag:  req_cnt[`DMA_TAG_W-1:0]};

  assign rdq_head       = rdq_mem[rdq_rd_ptr[QW-1:0]];
  assign lmem_req_valid = (rdq_wr_ptr != rdq_rd_ptr);
  // Replies drain window by window, so the write count gives the window base
  assign lmem_req = '{rw:   1'b1,
                      addr: lmem_base
                            + `DMA_LADDR_W'({wr_cnt[`DMA_CNT_W-1:`DMA_TAG_W], {`DMA_TAG_W{1'b0}}})
                            + `DMA_LADDR_W'(rdq_head.tag),
                      data: rdq_head.data};

  assign done = active && (wr_cnt == count_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      active     <= 1'b0;
      req_cnt    <= '0;
      rsp_cnt    <= '0;
      wr_cnt     <= '0;
      rdq_wr_ptr <= '0;
      rdq_rd_ptr <= '0;
    end else if (start) begin
      active  <= 1'b1;
      req_cnt <= '0;
      rsp_cnt <= '0;
      wr_cnt  <= '0;
    end else begin
      if (done) active <= 1'b0;
      if (rd_fire) req_cnt <= req_cnt + 1'b1;
      if (rsp_fire) begin
        rsp_cnt    <= rsp_cnt + 1'b1;
        rdq_wr_ptr <= rdq_wr_ptr + 1'b1;
      end
      if (wr_fire) begin
        wr_cnt     <= wr_cnt + 1'b1;
        rdq_rd_ptr <= rdq_rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      host_base <= cmd.host_addr;
      lmem_base <= cmd.lmem_addr;
      count_q   <= cmd.count;
    end
    if (rsp_fire) begin
      rdq_mem[rdq_wr_ptr[QW-1:0]] <= '{tag: host_rd_rsp.tag, data: host_rd_rsp.data};
      if (rsp_cnt[`DMA_TAG_W-1:0] == '0) begin
        tag_seen <= `DMA_WINDOW'(1) << host_rd_rsp.tag;   // First reply of window
      end else begin
        tag_seen[host_rd_rsp.tag] <= 1'b1;
      end
    end
  end

  a_tag_once: assert property (@(posedge clk) disable iff (reset)
    rsp_fire && (rsp_cnt[`DMA_TAG_W-1:0] != '0) |-> !tag_seen[host_rd_rsp.tag]);

endmodule

`default_nettype wire

// File: verilog/dma_cmd_ctrl.sv
`default_nettype none

`include "dma_cfg.svh"

module dma_cmd_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  host_if_pkg::mmio_req_t mmio_req,
  output host_if_pkg::mmio_rsp_t mmio_rsp,
  output logic                   to_lmem_start,
  output logic                   to_host_start,
  output dma_pkg::copy_cmd_t     cmd,
  input  logic                   to_lmem_done,
  input  logic                   to_host_done
);

  logic [`DMA_HADDR_W-1:0] host_addr_q;
  logic [`DMA_LADDR_W-1:0] lmem_addr_q;
  logic [`DMA_CNT_W-1:0]   size_q;
  dma_pkg::dma_state_e     state;
  dma_pkg::dma_cmd_e       cmd_code;
  logic                    cmd_wr;
  logic                    rsp_valid;
  logic [63:0]             rsp_data;

  assign cmd_wr   = mmio_req.wr_valid && (mmio_req.addr == `DMA_REG_CMD);
  assign cmd_code = dma_pkg::dma_cmd_e'(mmio_req.data[2:0]);

  // Commands only take effect when idle
  assign to_lmem_start = cmd_wr && (state == dma_pkg::IDLE) && (cmd_code == dma_pkg::CMD_TO_LMEM);
  assign to_host_start = cmd_wr && (state == dma_pkg::IDLE) && (cmd_code == dma_pkg::CMD_TO_HOST);

  assign cmd = '{host_addr: host_addr_q, lmem_addr: lmem_addr_q, count: size_q};

  always_ff @(posedge clk) begin
    if (mmio_req.wr_valid) begin
      case (mmio_req.addr)
        `DMA_REG_HOST_ADDR: host_addr_q <= mmio_req.data[`DMA_HADDR_W-1:0];
        `DMA_REG_LMEM_ADDR: lmem_addr_q <= mmio_req.data[`DMA_LADDR_W-1:0];
        `DMA_REG_SIZE:      size_q      <= mmio_req.data[`DMA_CNT_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= dma_pkg::IDLE;
    end else begin
      case (state)
        dma_pkg::IDLE: begin
          if (to_lmem_start) begin
            state <= dma_pkg::TO_LMEM;
          end else if (to_host_start) begin
            state <= dma_pkg::TO_HOST;
          end
        end
        dma_pkg::TO_LMEM: if (to_lmem_done) state <= dma_pkg::IDLE;
        dma_pkg::TO_HOST: if (to_host_done) state <= dma_pkg::IDLE;
        default: state <= dma_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= mmio_req.rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mmio_req.rd_valid) begin
      rsp_data <= (mmio_req.addr == `DMA_REG_STATUS) ? 64'(state) : 64'h0;
    end
  end

  assign mmio_rsp = '{valid: rsp_valid, data: rsp_data};

  // Engines finish only the copy they were started for
  a_lmem_done_busy: assert property (@(posedge clk) disable iff (reset)
    to_lmem_done |-> state == dma_pkg::TO_LMEM);
  a_host_done_busy: assert property (@(posedge clk) disable iff (reset)
    to_host_done |-> state == dma_pkg::TO_HOST);

endmodule

`default_nettype wire

// File: verilog/dma_pkg.sv
`default_nettype none

`include "dma_cfg.svh"

package dma_pkg;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    TO_LMEM = 2'd1,
    TO_HOST = 2'd2
  } dma_state_e;

  typedef enum logic [2:0] {
    CMD_NONE    = 3'd0,
    CMD_TO_LMEM = 3'd1,   // Host to local memory
    CMD_TO_HOST = 3'd2    // Local memory to host
  } dma_cmd_e;

  typedef struct packed {
    logic [`DMA_HADDR_W-1:0] host_addr;
    logic [`DMA_LADDR_W-1:0] lmem_addr;
    logic [`DMA_CNT_W-1:0]   count;
  } copy_cmd_t;

  typedef struct packed {
    logic                    rw;    // 1 = write
    logic [`DMA_LADDR_W-1:0] addr;
    logic [`DMA_LINE_W-1:0]  data;
  } lmem_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`DMA_LINE_W-1:0] data;
  } lmem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/host_if_pkg.sv
`default_nettype none

`include "dma_cfg.svh"

package host_if_pkg;

  typedef struct packed {
    logic                    wr_valid;
    logic                    rd_valid;
    logic [`DMA_MMIO_AW-1:0] addr;
    logic [63:0]             data;
  } mmio_req_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } mmio_rsp_t;

  typedef struct packed {
    logic [`DMA_HADDR_W-1:0] addr;
    logic [`DMA_TAG_W-1:0]   tag;
  } host_rd_req_t;

  // Reply tag echoes the request tag
  typedef struct packed {
    logic                   valid;
    logic [`DMA_TAG_W-1:0]  tag;
    logic [`DMA_LINE_W-1:0] data;
  } host_rd_rsp_t;

  typedef struct packed {
    logic [`DMA_HADDR_W-1:0] addr;
    logic [`DMA_LINE_W-1:0]  data;
  } host_wr_req_t;

endpackage

`default_nettype wire

// File: verilog/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`define DMA_LINE_W        64
`define DMA_HADDR_W       32
`define DMA_LADDR_W       16
`define DMA_CNT_W         16

`define DMA_WINDOW        8     // Host reads in flight per window
`define DMA_TAG_W         3
`define DMA_RDQ_DEPTH     16
`define DMA_ARB_DEPTH     8

`define DMA_MMIO_AW       16
`define DMA_REG_HOST_ADDR 16'h0010
`define DMA_REG_LMEM_ADDR 16'h0012
`define DMA_REG_SIZE      16'h0014
`define DMA_REG_CMD       16'h0016
`define DMA_REG_STATUS    16'h0018

`endif
